/* include/usb_crc.svh */
// USB CRC functions, evaluated LSB first in bus bit order
// Both registers shift towards the MSB, which holds the x^n-1 term

// CRC5 over the 11 token bits, returned as the 5-bit field
// Field bit 0 is the first CRC bit on the bus (token byte 2, bit 3)
function automatic logic [4:0] crc5(input logic [10:0] bits);
  logic [4:0] c;
  logic fb;
  c = 5'h1f;
  for (int i = 0; i < 11; i++) begin
    fb = c[4] ^ bits[i];
    c = {c[3:0], 1'b0} ^ (fb ? 5'h05 : 5'h00);
  end
  for (int i = 0; i < 5; i++) begin
    crc5[i] = ~c[4 - i];
  end
endfunction

// One byte folded into the CRC16 register (x^16 + x^15 + x^2 + 1)
function automatic logic [15:0] crc16(input logic [7:0] data, input logic [15:0] crc);
  logic [15:0] c;
  logic fb;
  c = crc;
  for (int i = 0; i < 8; i++) begin
    fb = c[15] ^ data[i];
    c = {c[14:0], 1'b0} ^ (fb ? 16'h8005 : 16'h0000);
  end
  return c;
endfunction

// Inverted, bit-reversed register as sent; low byte goes out first
function automatic logic [15:0] crc16_field(input logic [15:0] crc);
  logic [15:0] f;
  for (int i = 0; i < 16; i++) begin
    f[i] = ~crc[15 - i];
  end
  return f;
endfunction

/* verilog/usb_pkg.sv */
`default_nettype none

package usb_pkg;

  // PID codes, the upper nibble on the bus carries the complement
  typedef enum logic [3:0] {
    PID_OUT   = 4'b0001,
    PID_IN    = 4'b1001,
    PID_SOF   = 4'b0101,
    PID_SETUP = 4'b1101,
    PID_DATA0 = 4'b0011,
    PID_DATA1 = 4'b1011,
    PID_DATA2 = 4'b0111,
    PID_MDATA = 4'b1111,
    PID_ACK   = 4'b0010,
    PID_NAK   = 4'b1010,
    PID_STALL = 4'b1110,
    PID_NYET  = 4'b0110
  } usb_pid_e;

  // One byte from the ULPI receive stream
  typedef struct packed {
    logic       valid;
    logic       last;
    logic [7:0] data;
  } ulpi_byte_t;

  typedef struct packed {
    logic       valid;
    usb_pid_e   pid;
    logic [6:0] addr;
    logic [3:0] endp;
  } token_t;

  typedef struct packed {
    logic        valid;
    logic [10:0] frame;
  } sof_t;

  // Payload stream of a data packet, CRC bytes removed
  typedef struct packed {
    logic       start;
    usb_pid_e   pid;
    logic       valid;
    logic [7:0] data;
    logic       eop;
    logic       crc_ok;
  } rx_data_t;

  typedef struct packed {
    logic     valid;
    usb_pid_e pid;
  } hsk_t;

  // Register contents after a good packet and its CRC16 have been folded in
  localparam logic [15:0] DATA_CRC_RESIDUE = 16'h800d;

endpackage

`default_nettype wire

/* verilog/buf_pkg.sv */
`default_nettype none

package buf_pkg;

  localparam int NUM_EP    = 2;
  localparam int NUM_SLOTS = 2;
  localparam int MAX_PKT   = 64;

  localparam int EP_W   = $clog2(NUM_EP);
  localparam int SLOT_W = $clog2(NUM_SLOTS);
  localparam int OFS_W  = $clog2(MAX_PKT);
  localparam int LEN_W  = OFS_W + 1;
  // Endpoint index, slot, offset from MSB down, 8 bits in all
  localparam int ADDR_W = EP_W + SLOT_W + OFS_W;

  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] addr;
    logic [7:0]        data;
  } buf_wr_t;

  typedef struct packed {
    logic              valid;
    logic [EP_W-1:0]   ep;
    logic [SLOT_W-1:0] slot;
    logic [OFS_W-1:0]  offset;
  } rd_req_t;

  typedef struct packed {
    logic       valid;
    logic [7:0] data;
  } rd_resp_t;

  // Oldest committed packet of one endpoint
  typedef struct packed {
    logic              ready;
    logic [SLOT_W-1:0] slot;
    logic [LEN_W-1:0]  len;
  } pkt_status_t;

endpackage

`default_nettype wire

/* verilog/usb_packet_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module usb_packet_decoder (
  input  wire                  clock,
  input  wire                  reset,
  input  wire usb_pkg::ulpi_byte_t ulpi_i,
  output usb_pkg::token_t      token_o,
  output usb_pkg::sof_t        sof_o,
  output usb_pkg::rx_data_t    data_o,
  output logic                 crc_err_o
);
  import usb_pkg::*;

  `include "usb_crc.svh"

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_SOF,
    ST_TOKEN,
    ST_DATA,
    ST_SOF_CRC,
    ST_TOKEN_CRC,
    ST_DATA_CRC
  } state_e;

  state_e      state_q;
  ulpi_byte_t  rx_buf0_q;
  logic [7:0]  rx_buf1_q;
  logic        byte_seen_q;
  usb_pid_e    rx_pid;
  logic        pid_start;
  logic        data_pid;
  usb_pid_e    tok_pid_q;
  logic [10:0] tok_bits_q;
  logic [4:0]  tok_crc5_q;
  logic        tok_byte_q;
  logic [15:0] crc16_q;
  logic        crc5_match;
  logic        crc16_match;
  logic        tok_valid_q;
  logic        sof_valid_q;
  logic        dat_start_q;
  logic        dat_valid_q;
  logic        dat_eop_q;
  logic [7:0]  dat_byte_q;
  logic        crc_ok_q;

  // A PID byte is good when the upper nibble is the complement of the lower
  assign rx_pid = usb_pid_e'(rx_buf0_q.data[3:0]);
  assign pid_start = rx_buf0_q.valid && !rx_buf0_q.last &&
                     (rx_buf0_q.data[3:0] == ~rx_buf0_q.data[7:4]);
  assign data_pid = rx_pid inside {PID_DATA0, PID_DATA1, PID_DATA2, PID_MDATA};

  assign crc5_match  = crc5(tok_bits_q) == tok_crc5_q;
  assign crc16_match = crc16_q == DATA_CRC_RESIDUE;

  // First stage of the two-byte buffer, every received byte lands here
  always_ff @(posedge clock) begin
    if (reset) begin
      rx_buf0_q <= '0;
    end else begin
      rx_buf0_q <= ulpi_i;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (pid_start) begin
            case (rx_pid)
              PID_SOF:                    state_q <= ST_SOF;
              PID_OUT, PID_IN, PID_SETUP: state_q <= ST_TOKEN;
              default:                    state_q <= data_pid ? ST_DATA : ST_IDLE;
            endcase
          end
        end
        ST_SOF: begin
          if (rx_buf0_q.valid && rx_buf0_q.last) begin
            state_q <= ST_SOF_CRC;
          end
        end
        ST_TOKEN: begin
          if (rx_buf0_q.valid && rx_buf0_q.last) begin
            state_q <= ST_TOKEN_CRC;
          end
        end
        ST_DATA: begin
          if (rx_buf0_q.valid && rx_buf0_q.last) begin
            state_q <= ST_DATA_CRC;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Token and SOF fields, 11 bits followed by the CRC5
  always_ff @(posedge clock) begin
    if (state_q == ST_IDLE) begin
      tok_byte_q <= 1'b0;
      if (pid_start) begin
        tok_pid_q <= rx_pid;
      end
    end else if ((state_q == ST_SOF || state_q == ST_TOKEN) && rx_buf0_q.valid) begin
      tok_byte_q <= 1'b1;
      if (!tok_byte_q) begin
        tok_bits_q[7:0] <= rx_buf0_q.data;
      end else begin
        tok_bits_q[10:8] <= rx_buf0_q.data[2:0];
        tok_crc5_q <= rx_buf0_q.data[7:3];
      end
    end
  end

  // CRC16 runs over payload and CRC bytes, the PID is left out
  always_ff @(posedge clock) begin
    if (state_q != ST_DATA) begin
      crc16_q <= 16'hffff;
    end else if (rx_buf0_q.valid) begin
      crc16_q <= crc16(rx_buf0_q.data, crc16_q);
    end
  end

  // Second buffer stage, a byte leaves only once two more have arrived
  always_ff @(posedge clock) begin
    if (state_q == ST_DATA && rx_buf0_q.valid) begin
      rx_buf1_q <= rx_buf0_q.data;
    end
    if (state_q == ST_DATA && rx_buf0_q.valid && !rx_buf0_q.last) begin
      dat_byte_q <= rx_buf1_q;
    end
    if (state_q == ST_DATA_CRC) begin
      crc_ok_q <= crc16_match;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      byte_seen_q <= 1'b0;
      dat_start_q <= 1'b0;
      dat_valid_q <= 1'b0;
      dat_eop_q   <= 1'b0;
      tok_valid_q <= 1'b0;
      sof_valid_q <= 1'b0;
      crc_err_o   <= 1'b0;
    end else begin
      if (state_q != ST_DATA) begin
        byte_seen_q <= 1'b0;
      end else if (rx_buf0_q.valid) begin
        byte_seen_q <= 1'b1;
      end
      dat_start_q <= state_q == ST_IDLE && pid_start && data_pid;
      dat_valid_q <= state_q == ST_DATA && rx_buf0_q.valid && !rx_buf0_q.last &&
                     byte_seen_q;
      dat_eop_q   <= state_q == ST_DATA_CRC;
      tok_valid_q <= state_q == ST_TOKEN_CRC && crc5_match;
      sof_valid_q <= state_q == ST_SOF_CRC && crc5_match;
      // Error flag holds the result of the latest check
      if (state_q == ST_SOF_CRC || state_q == ST_TOKEN_CRC) begin
        crc_err_o <= !crc5_match;
      end else if (state_q == ST_DATA_CRC) begin
        crc_err_o <= !crc16_match;
      end
    end
  end

  assign token_o = '{valid: tok_valid_q, pid: tok_pid_q,
                     addr: tok_bits_q[6:0], endp: tok_bits_q[10:7]};
  assign sof_o   = '{valid: sof_valid_q, frame: tok_bits_q};
  assign data_o  = '{start: dat_start_q, pid: tok_pid_q, valid: dat_valid_q,
                     data: dat_byte_q, eop: dat_eop_q, crc_ok: crc_ok_q};

endmodule

`default_nettype wire

/* verilog/usb_out_endpoint.sv */
`timescale 1ns/1ns
`default_nettype none

module usb_out_endpoint #(
  parameter int EP_NUM = 1
) (
  input  wire                    clock,
  input  wire                    reset,
  input  wire usb_pkg::token_t   token_i,
  input  wire usb_pkg::rx_data_t data_i,
  input  wire [6:0]              dev_addr_i,
  input  wire                    credit_return_i,
  output buf_pkg::buf_wr_t       wr_o,
  output usb_pkg::hsk_t          hsk_o,
  output buf_pkg::pkt_status_t   pkt_o
);
  import usb_pkg::*;
  import buf_pkg::*;

  logic              armed_q;
  logic              rx_active_q;
  logic              accept_q;
  logic              overflow_q;
  logic              toggle_q;
  usb_pid_e          rx_pid_q;
  logic [LEN_W-1:0]  len_q;
  logic [SLOT_W-1:0] wr_slot_q;
  logic [SLOT_W-1:0] rd_slot_q;
  logic [SLOT_W:0]   credits_q;
  logic [LEN_W-1:0]  slot_len_q [NUM_SLOTS];
  logic              hsk_valid_q;
  usb_pid_e          hsk_pid_q;
  logic [EP_W-1:0]   ep_idx;
  logic              token_hit;
  logic              byte_wr;
  logic              pkt_end;
  logic              pkt_good;
  logic              commit;
  usb_pid_e          expect_pid;

  // EP1 owns the lowest region of the shared memory
  assign ep_idx = EP_W'(EP_NUM - 1);
  assign token_hit = token_i.valid && token_i.pid == PID_OUT &&
                     token_i.addr == dev_addr_i && token_i.endp == 4'(EP_NUM);

  assign byte_wr  = rx_active_q && accept_q && data_i.valid && len_q != LEN_W'(MAX_PKT);
  assign pkt_end  = rx_active_q && data_i.eop;
  assign pkt_good = data_i.crc_ok && !overflow_q;
  assign expect_pid = toggle_q ? PID_DATA1 : PID_DATA0;
  // A repeated toggle means the host missed our ACK, so it is not stored again
  assign commit = pkt_end && pkt_good && accept_q && rx_pid_q == expect_pid;

  always_ff @(posedge clock) begin
    if (reset) begin
      armed_q     <= 1'b0;
      rx_active_q <= 1'b0;
      toggle_q    <= 1'b0;
      wr_slot_q   <= '0;
      rd_slot_q   <= '0;
      credits_q   <= (SLOT_W + 1)'(NUM_SLOTS);
      hsk_valid_q <= 1'b0;
    end else begin
      if (token_i.valid) begin
        armed_q <= token_hit;
      end else if (data_i.start) begin
        armed_q <= 1'b0;
      end
      if (data_i.start) begin
        rx_active_q <= armed_q;
      end else if (data_i.eop) begin
        rx_active_q <= 1'b0;
      end
      hsk_valid_q <= pkt_end && pkt_good;
      if (commit) begin
        toggle_q  <= !toggle_q;
        wr_slot_q <= wr_slot_q + 1'b1;
      end
      if (credit_return_i) begin
        rd_slot_q <= rd_slot_q + 1'b1;
      end
      credits_q <= credits_q - (SLOT_W + 1)'(commit) + (SLOT_W + 1)'(credit_return_i);
    end
  end

  always_ff @(posedge clock) begin
    if (data_i.start) begin
      rx_pid_q   <= data_i.pid;
      accept_q   <= credits_q != '0;
      len_q      <= '0;
      overflow_q <= 1'b0;
    end else if (rx_active_q && data_i.valid) begin
      if (len_q == LEN_W'(MAX_PKT)) begin
        overflow_q <= 1'b1;
      end else begin
        len_q <= len_q + 1'b1;
      end
    end
    if (pkt_end) begin
      hsk_pid_q <= accept_q ? PID_ACK : PID_NAK;
    end
    if (commit) begin
      slot_len_q[wr_slot_q] <= len_q;
    end
  end

  assign wr_o  = '{valid: byte_wr, addr: {ep_idx, wr_slot_q, len_q[OFS_W-1:0]},
                   data: data_i.data};
  assign hsk_o = '{valid: hsk_valid_q, pid: hsk_pid_q};
  assign pkt_o = '{ready: credits_q != (SLOT_W + 1)'(NUM_SLOTS), slot: rd_slot_q,
                   len: slot_len_q[rd_slot_q]};

endmodule

`default_nettype wire

/* verilog/packet_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

module packet_buffer (
  input  wire                                        clock,
  input  wire                                        reset,
  input  wire buf_pkg::buf_wr_t [buf_pkg::NUM_EP-1:0] wr_i,
  input  wire buf_pkg::rd_req_t                      rd_req_i,
  output buf_pkg::rd_resp_t                          rd_o
);
  import buf_pkg::*;

  logic [7:0]        mem [2**ADDR_W];
  buf_wr_t           wr_sel;
  logic [ADDR_W-1:0] rd_addr;
  logic              rd_accept;
  logic              rd_valid_q;
  logic [7:0]        rd_data_q;

  // Only one endpoint is armed at a time, so at most one write is valid
  always_comb begin
    wr_sel = '0;
    for (int i = 0; i < NUM_EP; i++) begin
      if (wr_i[i].valid) begin
        wr_sel = wr_i[i];
      end
    end
  end

  assign rd_addr = {rd_req_i.ep, rd_req_i.slot, rd_req_i.offset};

  // Writes always win, a held read waits for a free cycle
  // Nothing is accepted while the previous response is on rd_o
  assign rd_accept = rd_req_i.valid && !wr_sel.valid && !rd_valid_q;

  always_ff @(posedge clock) begin
    if (wr_sel.valid) begin
      mem[wr_sel.addr] <= wr_sel.data;
    end
    if (rd_accept) begin
      rd_data_q <= mem[rd_addr];
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      rd_valid_q <= 1'b0;
    end else begin
      rd_valid_q <= rd_accept;
    end
  end

  assign rd_o = '{valid: rd_valid_q, data: rd_data_q};

endmodule

`default_nettype wire

/* verilog/usb_rx_top.sv */
`timescale 1ns/1ns
`default_nettype none

module usb_rx_top (
  input  wire                                           clock,
  input  wire                                           reset,
  input  wire usb_pkg::ulpi_byte_t                      ulpi_i,
  input  wire [6:0]                                     dev_addr_i,
  input  wire [buf_pkg::NUM_EP-1:0]                     credit_return_i,
  input  wire buf_pkg::rd_req_t                         rd_req_i,
  output wire usb_pkg::sof_t                            sof_o,
  output wire                                           crc_err_o,
  output wire usb_pkg::hsk_t [buf_pkg::NUM_EP-1:0]      hsk_o,
  output wire buf_pkg::pkt_status_t [buf_pkg::NUM_EP-1:0] pkt_o,
  output wire buf_pkg::rd_resp_t                        rd_o
);
  import usb_pkg::*;
  import buf_pkg::*;

  token_t                 token;
  rx_data_t               rx_data;
  buf_wr_t [NUM_EP-1:0]   buf_wr;

  usb_packet_decoder u_decoder (
    .clock     (clock),
    .reset     (reset),
    .ulpi_i    (ulpi_i),
    .token_o   (token),
    .sof_o     (sof_o),
    .data_o    (rx_data),
    .crc_err_o (crc_err_o)
  );

  // Entry 0 of every per-endpoint array belongs to EP1
  usb_out_endpoint #(
    .EP_NUM (1)
  ) u_ep1 (
    .clock           (clock),
    .reset           (reset),
    .token_i         (token),
    .data_i          (rx_data),
    .dev_addr_i      (dev_addr_i),
    .credit_return_i (credit_return_i[0]),
    .wr_o            (buf_wr[0]),
    .hsk_o           (hsk_o[0]),
    .pkt_o           (pkt_o[0])
  );

  usb_out_endpoint #(
    .EP_NUM (2)
  ) u_ep2 (
    .clock           (clock),
    .reset           (reset),
    .token_i         (token),
    .data_i          (rx_data),
    .dev_addr_i      (dev_addr_i),
    .credit_return_i (credit_return_i[1]),
    .wr_o            (buf_wr[1]),
    .hsk_o           (hsk_o[1]),
    .pkt_o           (pkt_o[1])
  );

  packet_buffer u_buffer (
    .clock    (clock),
    .reset    (reset),
    .wr_i     (buf_wr),
    .rd_req_i (rd_req_i),
    .rd_o     (rd_o)
  );

endmodule

`default_nettype wire

/* testbench/usb_rx_asserts.sv */
`timescale 1ns/1ns
`default_nettype none

module usb_rx_asserts (
  input wire                                         clock,
  input wire                                         reset,
  input wire [buf_pkg::NUM_EP-1:0]                   credit_return_i,
  input wire usb_pkg::hsk_t [buf_pkg::NUM_EP-1:0]       hsk_i,
  input wire buf_pkg::pkt_status_t [buf_pkg::NUM_EP-1:0] pkt_i,
  input wire buf_pkg::rd_req_t                       rd_req_i,
  input wire buf_pkg::rd_resp_t                      rd_i
);
  import buf_pkg::*;

  logic [NUM_EP-1:0] hsk_valid;
  logic [NUM_EP-1:0] pkt_ready;
  int                violation_count = 0;

  always_comb begin
    for (int i = 0; i < NUM_EP; i++) begin
      hsk_valid[i] = hsk_i[i].valid;
      pkt_ready[i] = pkt_i[i].ready;
    end
  end

  // Only one endpoint is armed, so only one may answer
  single_handshake: assert property (@(posedge clock) disable iff (reset)
    $onehot0(hsk_valid))
    else begin
      $error("more than one handshake valid in the same cycle");
      violation_count++;
    end

  credit_with_packet: assert property (@(posedge clock) disable iff (reset)
    (credit_return_i & ~pkt_ready) == '0)
    else begin
      $error("credit returned while no packet was ready");
      violation_count++;
    end

  // A pending read keeps its fields until the response arrives
  read_request_held: assert property (@(posedge clock) disable iff (reset)
    rd_req_i.valid && !rd_i.valid |=>
      rd_i.valid || (rd_req_i.valid && $stable(rd_req_i)))
    else begin
      $error("read request changed or dropped before its response");
      violation_count++;
    end

endmodule

`default_nettype wire

/* testbench/usb_rx_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module usb_rx_tb;
  import usb_pkg::*;
  import buf_pkg::*;

  `include "usb_crc.svh"

  localparam int         DRIVE_DELAY = 10;
  localparam int         TIMEOUT     = 400;
  localparam int         GAP         = 4;
  localparam logic [6:0] DEV_ADDR    = 7'h2a;

  // Outcomes of one OUT data packet
  localparam int RSP_NONE  = 0;
  localparam int RSP_STORE = 1;
  localparam int RSP_DUP   = 2;
  localparam int RSP_NAK   = 3;

  logic                     clock;
  logic                     reset;
  ulpi_byte_t               ulpi;
  logic [6:0]               dev_addr;
  logic [NUM_EP-1:0]        credit_return;
  rd_req_t                  rd_req;
  sof_t                     sof;
  logic                     crc_err;
  hsk_t [NUM_EP-1:0]        hsk;
  pkt_status_t [NUM_EP-1:0] pkt;
  rd_resp_t                 rd;

  logic [31:0] rng = 32'h1778_162f;
  string       test_name = "reset";
  int          mismatch_count = 0;
  int          error_count = 0;
  int          sof_count = 0;
  logic [10:0] sof_frame;
  int          exp_ep [$];
  usb_pid_e    exp_pid [$];

  // Model of each endpoint
  bit          toggle [NUM_EP];
  int          credits [NUM_EP];
  int          wr_slot [NUM_EP];
  int          rd_slot [NUM_EP];
  int          stored_len [NUM_EP][NUM_SLOTS];
  logic [7:0]  stored [NUM_EP][NUM_SLOTS][MAX_PKT];

  usb_rx_top dut0 (
    .clock           (clock),
    .reset           (reset),
    .ulpi_i          (ulpi),
    .dev_addr_i      (dev_addr),
    .credit_return_i (credit_return),
    .rd_req_i        (rd_req),
    .sof_o           (sof),
    .crc_err_o       (crc_err),
    .hsk_o           (hsk),
    .pkt_o           (pkt),
    .rd_o            (rd)
  );

  bind usb_rx_top usb_rx_asserts u_asserts (
    .clock           (clock),
    .reset           (reset),
    .credit_return_i (credit_return_i),
    .hsk_i           (hsk_o),
    .pkt_i           (pkt_o),
    .rd_req_i        (rd_req_i),
    .rd_i            (rd_o)
  );

  always #50 clock = ~clock;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  // Endpoint rules: CRC first, then credit, then toggle
  function automatic int expected_response(input bit armed, input bit crc_good,
                                           input int credits_left, input bit tgl,
                                           input usb_pid_e pid);
    if (!armed || !crc_good) begin
      return RSP_NONE;
    end
    if (credits_left == 0) begin
      return RSP_NAK;
    end
    return (pid == (tgl ? PID_DATA1 : PID_DATA0)) ? RSP_STORE : RSP_DUP;
  endfunction

  task automatic step();
    @(posedge clock);
    #DRIVE_DELAY;
  endtask

  task automatic check_value(input string what, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
    assert (exp_val == act_val) else begin
      mismatch_count++;
      $display("Mismatch in %s, %s: expected %0h, actual %0h", test_name, what,
               exp_val, act_val);
    end
  endtask

  task automatic report_error(input string msg);
    error_count++;
    $display("Error in %s: %s", test_name, msg);
  endtask

  task automatic send_bytes(input logic [7:0] bytes [$]);
    for (int i = 0; i < bytes.size(); i++) begin
      ulpi = '{valid: 1'b1, last: (i == bytes.size() - 1), data: bytes[i]};
      step();
    end
    ulpi = '0;
    repeat (GAP) step();
  endtask

  // Token or SOF, 11 bits then CRC5
  task automatic send_token(input usb_pid_e pid, input logic [10:0] bits, input bit bad_crc);
    logic [7:0] bytes [$];
    logic [4:0] crc;
    crc = crc5(bits) ^ {4'b0000, bad_crc};
    bytes.push_back({~4'(pid), 4'(pid)});
    bytes.push_back(bits[7:0]);
    bytes.push_back({crc, bits[10:8]});
    send_bytes(bytes);
  endtask

  task automatic send_data(input usb_pid_e pid, input logic [7:0] payload [$],
                           input bit bad_crc);
    logic [7:0]  bytes [$];
    logic [15:0] crc;
    logic [15:0] field;
    crc = 16'hffff;
    bytes.push_back({~4'(pid), 4'(pid)});
    foreach (payload[i]) begin
      crc = crc16(payload[i], crc);
      bytes.push_back(payload[i]);
    end
    field = crc16_field(crc) ^ {15'd0, bad_crc};
    bytes.push_back(field[7:0]);
    bytes.push_back(field[15:8]);
    send_bytes(bytes);
  endtask

  task automatic check_status(input int ep);
    check_value("pkt ready", 32'(credits[ep] != NUM_SLOTS), 32'(pkt[ep].ready));
    if (credits[ep] != NUM_SLOTS) begin
      check_value("pkt slot", 32'(rd_slot[ep]), 32'(pkt[ep].slot));
      check_value("pkt length", 32'(stored_len[ep][rd_slot[ep]]), 32'(pkt[ep].len));
    end
  endtask

  // OUT token and random data packet, handshake predicted by the model
  task automatic out_transfer(input logic [6:0] addr, input logic [3:0] endp,
                              input usb_pid_e pid, input bit bad_crc);
    logic [7:0] payload [$];
    int         len;
    int         ep;
    int         idx;
    int         rsp;
    int         wait_cnt;
    bit         armed;
    ep = int'(endp) - 1;
    armed = addr == DEV_ADDR && ep >= 0 && ep < NUM_EP;
    idx = armed ? ep : 0;
    len = int'(rng[5:0]) + 1;
    rng = xorshift32(rng);
    for (int i = 0; i < len; i++) begin
      payload.push_back(rng[7:0]);
      rng = xorshift32(rng);
    end
    rsp = expected_response(armed, !bad_crc, credits[idx], toggle[idx], pid);
    if (rsp != RSP_NONE) begin
      exp_ep.push_back(idx);
      exp_pid.push_back(rsp == RSP_NAK ? PID_NAK : PID_ACK);
    end
    send_token(PID_OUT, {endp, addr}, 1'b0);
    send_data(pid, payload, bad_crc);
    wait_cnt = 0;
    while (exp_ep.size() != 0 && wait_cnt < TIMEOUT) begin
      step();
      wait_cnt++;
    end
    assert (exp_ep.size() == 0) else report_error("expected handshake never arrived");
    check_value("crc_err", 32'(bad_crc), 32'(crc_err));
    if (rsp == RSP_STORE) begin
      for (int i = 0; i < len; i++) begin
        stored[idx][wr_slot[idx]][i] = payload[i];
      end
      stored_len[idx][wr_slot[idx]] = len;
      wr_slot[idx] = (wr_slot[idx] + 1) % NUM_SLOTS;
      credits[idx]--;
      toggle[idx] = !toggle[idx];
    end
    check_status(idx);
  endtask

  // Oldest packet read back byte by byte, then its credit goes back
  task automatic read_packet(input int ep);
    int slot;
    int wait_cnt;
    slot = rd_slot[ep];
    check_status(ep);
    for (int i = 0; i < stored_len[ep][slot]; i++) begin
      rd_req = '{valid: 1'b1, ep: EP_W'(ep), slot: SLOT_W'(slot), offset: OFS_W'(i)};
      wait_cnt = 0;
      step();
      while (!rd.valid && wait_cnt < TIMEOUT) begin
        step();
        wait_cnt++;
      end
      assert (rd.valid) else report_error("read response timed out");
      check_value("read byte", 32'(stored[ep][slot][i]), 32'(rd.data));
    end
    rd_req = '0;
    credit_return[ep] = 1'b1;
    step();
    credit_return = '0;
    rd_slot[ep] = (rd_slot[ep] + 1) % NUM_SLOTS;
    credits[ep]++;
    check_status(ep);
  endtask

  // Compares every handshake with the oldest expected one
  always @(negedge clock) begin
    int e;
    if (!reset && sof.valid) begin
      sof_count++;
      sof_frame = sof.frame;
    end
    if (!reset && (hsk[0].valid || hsk[1].valid)) begin
      assert (exp_ep.size() != 0) else report_error("handshake seen where none was expected");
      if (exp_ep.size() != 0) begin
        e = exp_ep.pop_front();
        check_value("hsk valid", 32'd1, 32'(hsk[e].valid));
        check_value("hsk pid", 32'(exp_pid.pop_front()), 32'(hsk[e].pid));
      end
    end
  end

  initial begin
    int          count0;
    int          wait_cnt;
    logic [10:0] frame;
    clock = 1'b0;
    reset = 1'b1;
    ulpi = '0;
    dev_addr = DEV_ADDR;
    credit_return = '0;
    rd_req = '0;
    for (int i = 0; i < NUM_EP; i++) begin
      toggle[i] = 1'b0;
      credits[i] = NUM_SLOTS;
      wr_slot[i] = 0;
      rd_slot[i] = 0;
    end
    repeat (2) @(posedge clock);
    #DRIVE_DELAY;
    reset = 1'b0;
    step();

    test_name = "sof";
    frame = rng[10:0];
    rng = xorshift32(rng);
    count0 = sof_count;
    send_token(PID_SOF, frame, 1'b0);
    wait_cnt = 0;
    while (sof_count == count0 && wait_cnt < TIMEOUT) begin
      step();
      wait_cnt++;
    end
    assert (sof_count == count0 + 1) else report_error("no SOF event after a good SOF");
    check_value("sof frame", 32'(frame), 32'(sof_frame));
    check_value("crc_err", 32'd0, 32'(crc_err));

    test_name = "sof bad crc5";
    count0 = sof_count;
    send_token(PID_SOF, frame, 1'b1);
    assert (sof_count == count0) else report_error("SOF event after a corrupted CRC5");
    check_value("crc_err", 32'd1, 32'(crc_err));

    test_name = "out data0";
    out_transfer(DEV_ADDR, 4'd1, PID_DATA0, 1'b0);
    read_packet(0);
    out_transfer(DEV_ADDR, 4'd2, PID_DATA0, 1'b0);
    read_packet(1);

    test_name = "bad crc16";
    out_transfer(DEV_ADDR, 4'd1, PID_DATA1, 1'b1);
    out_transfer(DEV_ADDR, 4'd1, PID_DATA1, 1'b0);
    read_packet(0);

    test_name = "repeated toggle";
    out_transfer(DEV_ADDR, 4'd1, PID_DATA1, 1'b0);

    test_name = "credits";
    out_transfer(DEV_ADDR, 4'd2, PID_DATA1, 1'b0);
    out_transfer(DEV_ADDR, 4'd2, PID_DATA0, 1'b0);
    out_transfer(DEV_ADDR, 4'd2, PID_DATA1, 1'b0);
    read_packet(1);
    out_transfer(DEV_ADDR, 4'd2, PID_DATA1, 1'b0);
    read_packet(1);
    read_packet(1);

    test_name = "other target";
    out_transfer(DEV_ADDR ^ 7'h01, 4'd1, PID_DATA0, 1'b0);
    out_transfer(DEV_ADDR, 4'd3, PID_DATA0, 1'b0);
    check_status(0);
    check_status(1);

    $display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
             mismatch_count, error_count, dut0.u_asserts.violation_count);
    if (mismatch_count == 0 && error_count == 0 && dut0.u_asserts.violation_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+include
verilog/usb_pkg.sv
verilog/buf_pkg.sv
verilog/usb_packet_decoder.sv
verilog/usb_out_endpoint.sv
verilog/packet_buffer.sv
verilog/usb_rx_top.sv
testbench/usb_rx_asserts.sv
testbench/usb_rx_tb.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f verilog.f --top-module usb_rx_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vusb_rx_tb +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulator returned status $status"
  exit 1
fi

if grep -q "^Simulation PASSED$" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
